//--- common/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DECODE_REG_COUNT 32
`define DECODE_RA 5'd31

// primary opcodes
`define OP_RTYPE 6'b000000
`define OP_REGIMM 6'b000001
`define OP_J 6'b000010
`define OP_JAL 6'b000011
`define OP_BEQ 6'b000100
`define OP_BNE 6'b000101
`define OP_BLEZ 6'b000110
`define OP_BGTZ 6'b000111
`define OP_ADDI 6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI 6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI 6'b001100
`define OP_ORI 6'b001101
`define OP_XORI 6'b001110
`define OP_LUI 6'b001111
`define OP_COP0 6'b010000
`define OP_SPECIAL2 6'b011100
`define OP_LB 6'b100000
`define OP_LH 6'b100001
`define OP_LW 6'b100011
`define OP_LBU 6'b100100
`define OP_LHU 6'b100101
`define OP_SB 6'b101000
`define OP_SH 6'b101001
`define OP_SW 6'b101011

// SPECIAL funct
`define FN_SLL 6'b000000
`define FN_SRL 6'b000010
`define FN_SRA 6'b000011
`define FN_SLLV 6'b000100
`define FN_SRLV 6'b000110
`define FN_SRAV 6'b000111
`define FN_JR 6'b001000
`define FN_JALR 6'b001001
`define FN_MOVZ 6'b001010
`define FN_MOVN 6'b001011
`define FN_SYSCALL 6'b001100
`define FN_BREAK 6'b001101
`define FN_MFHI 6'b010000
`define FN_MTHI 6'b010001
`define FN_MFLO 6'b010010
`define FN_MTLO 6'b010011
`define FN_MULT 6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV 6'b011010
`define FN_DIVU 6'b011011
`define FN_ADD 6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB 6'b100010
`define FN_SUBU 6'b100011
`define FN_AND 6'b100100
`define FN_OR 6'b100101
`define FN_XOR 6'b100110
`define FN_NOR 6'b100111
`define FN_SLT 6'b101010
`define FN_SLTU 6'b101011
`define FN_TGE 6'b110000
`define FN_TGEU 6'b110001
`define FN_TLT 6'b110010
`define FN_TLTU 6'b110011
`define FN_TEQ 6'b110100
`define FN_TNE 6'b110110

// SPECIAL2 funct
`define F2_MADD 6'b000000
`define F2_MADDU 6'b000001
`define F2_MUL 6'b000010
`define F2_MSUB 6'b000100
`define F2_MSUBU 6'b000101
`define F2_CLZ 6'b100000
`define F2_CLO 6'b100001

// REGIMM rt selector
`define RT_BLTZ 5'b00000
`define RT_BGEZ 5'b00001
`define RT_TGEI 5'b01000
`define RT_TGEIU 5'b01001
`define RT_TLTI 5'b01010
`define RT_TLTIU 5'b01011
`define RT_TEQI 5'b01100
`define RT_TNEI 5'b01110
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

// COP0 rs selector, and funct when the CO bit is set
`define RS_MFC0 5'b00000
`define RS_MTC0 5'b00100
`define CO_TLBR 6'b000001
`define CO_TLBWI 6'b000010
`define CO_TLBWR 6'b000110
`define CO_TLBP 6'b001000
`define CO_ERET 6'b011000

`endif

//--- common/decodePkg.sv
`include "decode_defs.svh"

package decodePkg;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeFields;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iTypeFields;

	typedef union packed {
		rTypeFields rFields;
		iTypeFields iFields;
	} instrWord;

	// immediate ops share their opcode value
	typedef enum logic [5:0] {
		aluRType = 6'h00,
		aluAddi = `OP_ADDI,
		aluAddiu = `OP_ADDIU,
		aluSlti = `OP_SLTI,
		aluSltiu = `OP_SLTIU,
		aluAndi = `OP_ANDI,
		aluOri = `OP_ORI,
		aluXori = `OP_XORI,
		aluLui = `OP_LUI,
		aluMem = 6'h10,
		aluRotr = 6'h11,
		aluRotrv = 6'h12,
		aluMul = 6'h13,
		aluMadd = 6'h14,
		aluMaddu = 6'h15,
		aluMsub = 6'h16,
		aluMsubu = 6'h17,
		aluClo = 6'h18,
		aluClz = 6'h19,
		aluMfc0 = 6'h1a,
		aluMtc0 = 6'h1b,
		aluUseless = 6'h3f
	} aluOp;

	typedef enum logic [2:0] {
		brNone = 3'd0,
		brEq = 3'd1,
		brNe = 3'd2,
		brLez = 3'd3,
		brGtz = 3'd4,
		brLtz = 3'd5,
		brGez = 3'd6
	} branchKind;

	typedef enum logic [1:0] {
		dstRd = 2'b00,
		dstRt = 2'b01,
		dstRa = 2'b10
	} regDstSel;

	typedef struct packed {
		logic regWrite;
		regDstSel regDst;
		logic [4:0] destReg;
		logic aluSrcImm;
		logic signExtend;
		logic memRead;
		logic memWrite;
		logic memToReg;
		aluOp alu;
		logic [5:0] functToAlu;
		logic divMulEn;
		logic hiloToReg;
		logic mfhi;
		logic mflo;
		logic cp0Write;
		logic cp0ToReg;
		logic eret;
		logic syscall;
		logic brk;
		logic reservedInstr;
	} ctrlBundle;

	typedef struct packed {
		ctrlBundle ctrl;
		logic [31:0] rsValue;
		logic [31:0] rtValue;
		logic [31:0] immValue;
		logic [31:0] pcPlus8;
		logic valid;
	} execBundle;

endpackage

//--- decode/mainDecoder.sv
`include "decode_defs.svh"

module mainDecoder (
	input decodePkg::instrWord instr,
	output decodePkg::ctrlBundle ctrl,
	output decodePkg::branchKind kind,
	output logic isJump,
	output logic isJumpReg
);
	import decodePkg::*;

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] shamt;
	logic rType;
	logic cop0;
	logic special2;
	logic link;
	logic coLegal;

	assign op = instr.iFields.op;
	assign rs = instr.iFields.rs;
	assign rt = instr.iFields.rt;
	assign rd = instr.rFields.rd;
	assign shamt = instr.rFields.shamt;
	assign funct = instr.rFields.funct;

	assign rType = op == `OP_RTYPE;
	assign cop0 = op == `OP_COP0;
	assign special2 = op == `OP_SPECIAL2;
	assign isJump = op == `OP_J || op == `OP_JAL;
	assign isJumpReg = rType && (funct == `FN_JR || funct == `FN_JALR);
	assign link = op == `OP_JAL || (rType && funct == `FN_JALR)
		|| (op == `OP_REGIMM && (rt == `RT_BLTZAL || rt == `RT_BGEZAL));
	// CO bit set: eret and the tlb ops are legal
	assign coLegal = rs[4] && (funct inside {`CO_ERET, `CO_TLBR, `CO_TLBWI, `CO_TLBWR, `CO_TLBP});

	always_comb begin
		ctrl = '0;
		ctrl.regDst = dstRd;
		ctrl.destReg = rd;
		ctrl.alu = aluUseless;
		ctrl.functToAlu = funct;
		ctrl.signExtend = op[5:2] != 4'b0011; // andi ori xori lui zero-extend
		ctrl.divMulEn = (rType && funct inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU})
			|| (special2 && funct inside {`F2_MUL, `F2_MADD, `F2_MADDU, `F2_MSUB, `F2_MSUBU});
		ctrl.mfhi = rType && funct == `FN_MFHI;
		ctrl.mflo = rType && funct == `FN_MFLO;
		ctrl.hiloToReg = ctrl.mfhi || ctrl.mflo;
		ctrl.syscall = rType && funct == `FN_SYSCALL;
		ctrl.brk = rType && funct == `FN_BREAK;
		ctrl.cp0Write = cop0 && rs == `RS_MTC0;
		ctrl.cp0ToReg = cop0 && rs == `RS_MFC0;
		ctrl.eret = cop0 && rs[4] && funct == `CO_ERET;

		case (op)
			`OP_RTYPE: begin
				ctrl.alu = aluRType;
				case (funct)
					`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU,
					`FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLL, `FN_SRA,
					`FN_SLLV, `FN_SRAV, `FN_MOVN, `FN_MOVZ, `FN_MFHI, `FN_MFLO:
						ctrl.regWrite = 1'b1;
					`FN_SRL: begin
						ctrl.regWrite = 1'b1;
						if (rs[0])
							ctrl.alu = aluRotr;
					end
					`FN_SRLV: begin
						ctrl.regWrite = 1'b1;
						if (shamt[0])
							ctrl.alu = aluRotrv;
					end
					// hilo, traps and jumps write nothing here
					`FN_JR, `FN_JALR, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU,
					`FN_MTHI, `FN_MTLO, `FN_SYSCALL, `FN_BREAK, `FN_TGE, `FN_TGEU,
					`FN_TLT, `FN_TLTU, `FN_TEQ, `FN_TNE:
						ctrl.regWrite = 1'b0;
					default: begin
						ctrl.alu = aluUseless;
						ctrl.reservedInstr = 1'b1;
					end
				endcase
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.destReg = rt;
				ctrl.aluSrcImm = 1'b1;
				ctrl.alu = aluOp'(op);
			end
			`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J, `OP_JAL:
				ctrl.alu = aluUseless; // resolved in branchUnit
			`OP_REGIMM: begin
				case (rt)
					`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL, `RT_TGEI, `RT_TGEIU,
					`RT_TLTI, `RT_TLTIU, `RT_TEQI, `RT_TNEI:
						ctrl.alu = aluUseless;
					default:
						ctrl.reservedInstr = 1'b1;
				endcase
			end
			`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.destReg = rt;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.alu = aluMem;
			end
			`OP_SB, `OP_SH, `OP_SW: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.alu = aluMem;
			end
			`OP_COP0: begin
				case (rs)
					`RS_MTC0:
						ctrl.alu = aluMtc0;
					`RS_MFC0: begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = dstRt;
						ctrl.destReg = rt;
						ctrl.alu = aluMfc0;
					end
					default:
						ctrl.reservedInstr = !coLegal;
				endcase
			end
			`OP_SPECIAL2: begin
				ctrl.regWrite = funct inside {`F2_CLO, `F2_CLZ, `F2_MUL};
				case (funct)
					`F2_CLO: ctrl.alu = aluClo;
					`F2_CLZ: ctrl.alu = aluClz;
					`F2_MUL: ctrl.alu = aluMul;
					`F2_MADD: ctrl.alu = aluMadd;
					`F2_MADDU: ctrl.alu = aluMaddu;
					`F2_MSUB: ctrl.alu = aluMsub;
					`F2_MSUBU: ctrl.alu = aluMsubu;
					default: ctrl.reservedInstr = 1'b1;
				endcase
			end
			default:
				ctrl.reservedInstr = 1'b1;
		endcase

		if (link) begin // jal, jalr, bltzal, bgezal
			ctrl.regWrite = 1'b1;
			ctrl.regDst = dstRa;
			ctrl.destReg = `DECODE_RA;
		end
	end

	always_comb begin
		case (op)
			`OP_BEQ: kind = brEq;
			`OP_BNE: kind = brNe;
			`OP_BLEZ: kind = brLez;
			`OP_BGTZ: kind = brGtz;
			`OP_REGIMM: begin
				case (rt)
					`RT_BLTZ, `RT_BLTZAL: kind = brLtz;
					`RT_BGEZ, `RT_BGEZAL: kind = brGez;
					default: kind = brNone; // traps never redirect
				endcase
			end
			default: kind = brNone;
		endcase
	end

endmodule

//--- decode/registerFile.sv
`include "decode_defs.svh"

module registerFile (
	input logic clk,
	input logic reset,
	input logic [4:0] readAddrA,
	input logic [4:0] readAddrB,
	output logic [31:0] readDataA,
	output logic [31:0] readDataB,
	input logic writeEnable,
	input logic [4:0] writeAddr,
	input logic [31:0] writeData
);

	logic [31:0] regs [`DECODE_REG_COUNT];

	// $zero, then write-through bypass, then the array
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'd0;
		if (writeEnable && addr == writeAddr)
			return writeData;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DECODE_REG_COUNT; i++)
				regs[i] <= 32'd0;
		end else if (writeEnable && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

//--- decode/branchUnit.sv
module branchUnit (
	input decodePkg::branchKind kind,
	input logic isJump,
	input logic isJumpReg,
	input logic [31:0] rsValue,
	input logic [31:0] rtValue,
	input logic [31:0] immExt,
	input logic [25:0] jumpIndex,
	input logic [31:0] pc,
	output logic redirect,
	output logic [31:0] target
);
	import decodePkg::*;

	logic [31:0] pcPlus4;
	logic taken;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		case (kind)
			brEq: taken = rsValue == rtValue;
			brNe: taken = rsValue != rtValue;
			brLez: taken = $signed(rsValue) <= 32'sd0;
			brGtz: taken = $signed(rsValue) > 32'sd0;
			brLtz: taken = $signed(rsValue) < 32'sd0;
			brGez: taken = $signed(rsValue) >= 32'sd0;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (isJumpReg)
			target = rsValue;
		else if (isJump)
			target = {pcPlus4[31:28], jumpIndex, 2'b00}; // region of the delay slot
		else
			target = pcPlus4 + {immExt[29:0], 2'b00};
	end

	assign redirect = taken || isJump || isJumpReg;

endmodule

//--- src/decodeStage.sv
module decodeStage (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input decodePkg::instrWord instr,
	input logic [31:0] pc,
	input logic wbEnable,
	input logic [4:0] wbReg,
	input logic [31:0] wbData,
	output logic redirect,
	output logic [31:0] target,
	output decodePkg::execBundle execOut
);
	import decodePkg::*;

	ctrlBundle ctrl;
	branchKind kind;
	logic isJump;
	logic isJumpReg;
	logic [31:0] rsValue;
	logic [31:0] rtValue;
	logic [31:0] immExt;
	logic [15:0] imm16;

	assign imm16 = instr.iFields.imm16;
	assign immExt = ctrl.signExtend ? {{16{imm16[15]}}, imm16} : {16'd0, imm16};

	mainDecoder mainDecoder_i (
		.instr(instr),
		.ctrl(ctrl),
		.kind(kind),
		.isJump(isJump),
		.isJumpReg(isJumpReg)
	);

	registerFile registerFile_i (
		.clk(clk),
		.reset(reset),
		.readAddrA(instr.iFields.rs),
		.readAddrB(instr.iFields.rt),
		.readDataA(rsValue),
		.readDataB(rtValue),
		.writeEnable(wbEnable),
		.writeAddr(wbReg),
		.writeData(wbData)
	);

	branchUnit branchUnit_i (
		.kind(kind),
		.isJump(isJump),
		.isJumpReg(isJumpReg),
		.rsValue(rsValue),
		.rtValue(rtValue),
		.immExt(immExt),
		.jumpIndex(instr[25:0]),
		.pc(pc),
		.redirect(redirect),
		.target(target)
	);

	// flush beats stall
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			execOut <= '0;
		end else if (!stall) begin
			execOut <= '{
				ctrl: ctrl,
				rsValue: rsValue,
				rtValue: rtValue,
				immValue: immExt,
				pcPlus8: pc + 32'd8, // link value past the delay slot
				valid: 1'b1
			};
		end
	end

endmodule

//--- tb/clockGen.sv
module clockGen #(
	parameter int halfPeriod = 2,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- tb/decodeStage_properties.sv
`include "decode_defs.svh"

module decodeStage_properties (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic [31:0] instr,
	input logic [31:0] pc,
	input logic wbEnable,
	input logic [4:0] wbReg,
	input logic [31:0] wbData,
	input logic redirect,
	input logic [31:0] target,
	input decodePkg::execBundle execOut
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] shadow [`DECODE_REG_COUNT];
	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [31:0] rsExp;
	logic [31:0] rtExp;
	logic [31:0] immSext;
	logic [31:0] immExp;
	logic [31:0] pcNext;
	logic [31:0] expTarget;
	logic taken;
	logic isJ;
	logic isJr;
	logic isLink;
	logic expRedirect;
	logic undefinedWord;
	logic go;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];
	assign go = !reset && !flush && !stall;

	// expected register contents, fed from the write-back port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DECODE_REG_COUNT; i++)
				shadow[i] <= 32'd0;
		end else if (wbEnable && wbReg != 5'd0) begin
			shadow[wbReg] <= wbData;
		end
	end

	function automatic logic [31:0] expectedRead(input logic [4:0] addr);
		logic [31:0] value;
		value = shadow[addr];
		if (wbEnable && wbReg == addr)
			value = wbData; // same-cycle write
		if (addr == 5'd0)
			value = 32'd0;
		return value;
	endfunction

	always_comb begin
		rsExp = expectedRead(rs);
		rtExp = expectedRead(rt);
		immSext = {{16{instr[15]}}, instr[15:0]};
		// logical immediates and lui are unsigned
		if (op inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI})
			immExp = {16'd0, instr[15:0]};
		else
			immExp = immSext;
		pcNext = pc + 32'd4;
		isJ = op inside {`OP_J, `OP_JAL};
		isJr = op == `OP_RTYPE && funct inside {`FN_JR, `FN_JALR};
		isLink = op == `OP_JAL || (op == `OP_RTYPE && funct == `FN_JALR)
			|| (op == `OP_REGIMM && rt inside {`RT_BLTZAL, `RT_BGEZAL});
		case (op)
			`OP_BEQ: taken = rsExp == rtExp;
			`OP_BNE: taken = rsExp != rtExp;
			`OP_BLEZ: taken = rsExp[31] || rsExp == 32'd0;
			`OP_BGTZ: taken = !rsExp[31] && rsExp != 32'd0;
			`OP_REGIMM: taken = (rt inside {`RT_BLTZ, `RT_BLTZAL} && rsExp[31])
				|| (rt inside {`RT_BGEZ, `RT_BGEZAL} && !rsExp[31]);
			default: taken = 1'b0;
		endcase
		expRedirect = taken || isJ || isJr;
		if (isJr)
			expTarget = rsExp;
		else if (isJ)
			expTarget = {pcNext[31:28], instr[25:0], 2'b00};
		else
			expTarget = pcNext + (immSext << 2);
		undefinedWord = !(op inside {`OP_RTYPE, `OP_REGIMM, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE,
			`OP_BLEZ, `OP_BGTZ, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
			`OP_XORI, `OP_LUI, `OP_COP0, `OP_SPECIAL2, `OP_LB, `OP_LH, `OP_LW, `OP_LBU,
			`OP_LHU, `OP_SB, `OP_SH, `OP_SW})
			|| (op == `OP_RTYPE && !(funct inside {`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV,
			`FN_SRLV, `FN_SRAV, `FN_JR, `FN_JALR, `FN_MOVZ, `FN_MOVN, `FN_SYSCALL,
			`FN_BREAK, `FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO, `FN_MULT, `FN_MULTU,
			`FN_DIV, `FN_DIVU, `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
			`FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_TGE, `FN_TGEU, `FN_TLT, `FN_TLTU,
			`FN_TEQ, `FN_TNE}));
	end

	clearOnReset: assert property (@(posedge clk)
		(reset || flush) |=> !execOut.valid && !execOut.ctrl.regWrite
			&& !execOut.ctrl.memRead && !execOut.ctrl.memWrite)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: bundle not cleared after reset or flush", $time);
		end

	immediateAlu: assert property (@(posedge clk) disable iff (reset)
		go && op inside {`OP_ADDIU, `OP_ORI, `OP_LUI} |=> execOut.valid
			&& execOut.ctrl.regWrite && execOut.ctrl.aluSrcImm && !execOut.ctrl.reservedInstr
			&& execOut.ctrl.destReg == $past(rt) && execOut.immValue == $past(immExp))
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: immediate ALU fields wrong", $time);
		end

	registerAlu: assert property (@(posedge clk) disable iff (reset)
		go && op == `OP_RTYPE && funct inside {`FN_ADDU, `FN_SUBU, `FN_OR, `FN_SLT}
			|=> execOut.ctrl.regWrite && !execOut.ctrl.aluSrcImm
			&& execOut.ctrl.destReg == $past(rd))
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: R-type fields wrong", $time);
		end

	loadStrobes: assert property (@(posedge clk) disable iff (reset)
		go && op == `OP_LW |=> execOut.ctrl.memRead && execOut.ctrl.memToReg
			&& execOut.ctrl.regWrite && !execOut.ctrl.memWrite)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: load strobes wrong", $time);
		end

	storeStrobes: assert property (@(posedge clk) disable iff (reset)
		go && op == `OP_SW |=> execOut.ctrl.memWrite && !execOut.ctrl.regWrite
			&& !execOut.ctrl.memRead)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: store strobes wrong", $time);
		end

	redirectLevel: assert property (@(posedge clk) disable iff (reset)
		redirect == expRedirect)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: redirect %0b, expected %0b", $time, redirect, expRedirect);
		end

	redirectTarget: assert property (@(posedge clk) disable iff (reset)
		expRedirect |-> target == expTarget)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: target %h, expected %h", $time, target, expTarget);
		end

	linkFields: assert property (@(posedge clk) disable iff (reset)
		go && isLink |=> execOut.ctrl.regWrite && execOut.ctrl.destReg == `DECODE_RA
			&& execOut.pcPlus8 == $past(pc) + 32'd8)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: link destination or return address wrong", $time);
		end

	operandValues: assert property (@(posedge clk) disable iff (reset)
		go |=> execOut.rsValue == $past(rsExp) && execOut.rtValue == $past(rtExp))
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: register operand values wrong", $time);
		end

	reservedWord: assert property (@(posedge clk) disable iff (reset)
		go && undefinedWord |=> execOut.ctrl.reservedInstr && !execOut.ctrl.regWrite
			&& !execOut.ctrl.memRead && !execOut.ctrl.memWrite)
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: undefined word not marked reserved", $time);
		end

	stallHolds: assert property (@(posedge clk) disable iff (reset)
		!flush && stall |=> $stable(execOut))
		else begin
			tb.assertFails = tb.assertFails + 1;
			$error("Fail %0t: output register changed under stall", $time);
		end

endmodule

//--- tb/tb.sv
`include "decode_defs.svh"

module tb;
	timeunit 1ns;
	timeprecision 100ps;
	import decodePkg::*;

	localparam int rounds = 6;
	localparam int perRound = 22;
	// reset, preload and tail cycles around the rounds
	localparam int cycleCount = 2 + 17 + rounds * perRound + 24;
	localparam int timeoutNs = cycleCount * 4 + 200;

	logic clk;
	logic reset;
	logic stall;
	logic flush;
	instrWord instr;
	logic [31:0] pc;
	logic wbEnable;
	logic [4:0] wbReg;
	logic [31:0] wbData;
	logic redirect;
	logic [31:0] target;
	execBundle execOut;

	int assertFails = 0;
	int issued = 0;
	logic [15:0] lfsrState = 16'd16;

	clockGen #(.halfPeriod(2), .resetCycles(2)) clockGen_i (
		.clk(clk),
		.reset(reset)
	);

	decodeStage decodeStage_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.instr(instr),
		.pc(pc),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.redirect(redirect),
		.target(target),
		.execOut(execOut)
	);

	bind decodeStage decodeStage_properties props_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.flush(flush),
		.instr(instr),
		.pc(pc),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.redirect(redirect),
		.target(target),
		.execOut(execOut)
	);

	// taps 16 14 13 11
	function automatic logic nextRandomBit();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], nextRandomBit()};
		return v;
	endfunction

	function automatic logic [31:0] randomPc();
		return randomBits(30) << 2;
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] funct);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] jWord(input logic [5:0] op, input logic [25:0] index);
		return {op, index};
	endfunction

	task automatic drive(input logic [31:0] word, input logic [31:0] pcValue,
			input logic wbOn, input logic [4:0] regAddr, input logic [31:0] data);
		@(negedge clk);
		instr = word;
		pc = pcValue;
		wbEnable = wbOn;
		wbReg = regAddr;
		wbData = data;
		issued++;
	endtask

	task automatic issue(input logic [31:0] word, input logic [31:0] pcValue);
		drive(word, pcValue, 1'b0, 5'd0, 32'd0);
	endtask

	task automatic preload(input logic [4:0] regAddr, input logic [31:0] data);
		drive(32'd0, 32'd0, 1'b1, regAddr, data); // nop alongside
	endtask

	task automatic pulseFlush(input logic [31:0] word, input logic withStall);
		issue(word, randomPc());
		flush = 1'b1;
		stall = withStall;
		@(negedge clk);
		flush = 1'b0;
		stall = 1'b0;
	endtask

	task automatic stallFor(input int cycles);
		stall = 1'b1;
		repeat (cycles)
			issue(iWord(`OP_ADDIU, 5'(randomBits(5)), 5'(randomBits(5)), 16'(randomBits(16))),
				randomPc());
		stall = 1'b0;
	endtask

	initial begin
		logic [31:0] same;
		logic [4:0] a;
		logic [4:0] b;
		logic [4:0] c;
		logic [15:0] imm;
		logic [31:0] pcR;

		stall = 1'b0;
		flush = 1'b0;
		instr = '0;
		pc = 32'd0;
		wbEnable = 1'b0;
		wbReg = 5'd0;
		wbData = 32'd0;
		@(negedge reset);

		for (int r = 1; r < 16; r++)
			preload(5'(r), randomBits(32));
		same = randomBits(32);
		preload(5'd16, same);
		preload(5'd17, same);

		for (int k = 0; k < rounds; k++) begin
			a = 5'(randomBits(5));
			b = 5'(randomBits(5));
			c = 5'(randomBits(5));
			imm = 16'(randomBits(16));
			pcR = randomPc();
			issue(iWord(`OP_ADDIU, a, b, imm), pcR);
			issue(iWord(`OP_ORI, a, b, imm), pcR);
			issue(iWord(`OP_LUI, 5'd0, b, imm), pcR);
			issue(rWord(a, b, c, `FN_ADDU), pcR);
			issue(rWord(a, b, c, `FN_SUBU), pcR);
			issue(rWord(a, b, c, `FN_OR), pcR);
			issue(rWord(a, b, c, `FN_SLT), pcR);
			issue(iWord(`OP_LW, a, b, imm), pcR);
			issue(iWord(`OP_SW, a, b, imm), pcR);
			issue(iWord(`OP_BEQ, a, b, imm), pcR);
			issue(iWord(`OP_BEQ, 5'd16, 5'd17, imm), pcR); // equal operands
			issue(iWord(`OP_BNE, a, b, imm), pcR);
			issue(iWord(`OP_BLEZ, a, 5'd0, imm), pcR);
			issue(iWord(`OP_BGTZ, a, 5'd0, imm), pcR);
			issue(iWord(`OP_REGIMM, a, `RT_BLTZ, imm), pcR);
			issue(iWord(`OP_REGIMM, a, `RT_BGEZ, imm), pcR);
			issue(jWord(`OP_J, 26'(randomBits(26))), pcR);
			issue(jWord(`OP_JAL, 26'(randomBits(26))), pcR);
			issue(rWord(a, 5'd0, 5'd0, `FN_JR), pcR);
			issue(rWord(a, 5'd0, 5'd31, `FN_JALR), pcR);
			issue(iWord(`OP_REGIMM, a, `RT_BGEZAL, imm), pcR);
			issue(iWord(`OP_REGIMM, a, `RT_BLTZAL, imm), pcR);
		end

		// read while writing, and a write to $zero
		drive(rWord(5'd5, 5'd6, 5'd7, `FN_ADDU), 32'h100, 1'b1, 5'd5, randomBits(32));
		drive(rWord(5'd0, 5'd5, 5'd7, `FN_ADDU), 32'h104, 1'b1, 5'd0, 32'h5a5a_0001);
		issue(rWord(5'd0, 5'd5, 5'd7, `FN_ADDU), 32'h108);

		issue(iWord(6'b010011, a, b, imm), 32'h10c);
		issue(iWord(6'b110000, a, b, imm), 32'h110);
		issue(rWord(a, b, c, 6'b000001), 32'h114);
		issue(rWord(a, b, c, 6'b111111), 32'h118);

		pulseFlush(iWord(`OP_LW, a, b, imm), 1'b0);
		issue(iWord(`OP_ADDIU, a, b, imm), 32'h11c);
		stallFor(3);
		pulseFlush(iWord(`OP_SW, a, b, imm), 1'b1); // flush over stall
		repeat (3)
			issue(32'd0, 32'd0);
		@(negedge clk);

		$display("Assertion failures: %0d, instructions issued: %0d", assertFails, issued);
		if (assertFails == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the stimulus did not finish within %0d ns", timeoutNs);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+common
common/decodePkg.sv
decode/mainDecoder.sv
decode/registerFile.sv
decode/branchUnit.sv
src/decodeStage.sv
tb/clockGen.sv
tb/decodeStage_properties.sv
tb/tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb \
	-f tb.f --Mdir "$buildDir" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/simv" +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Verification passed" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1
